//--- execute_core.f
+incdir+.
riscv_isa_pkg.sv
exec_cfg_pkg.sv
forwarding_unit.sv
alu.sv
stage_execute.sv
id_ex_reg.sv
ex_mem_reg.sv
execute_core.sv
tb_execute_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execute core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --timescale 1ns/10ps \
    --top-module tb_execute_core -f execute_core.f -o sim_execute_core

# A failing run may exit non-zero, the output still decides
output="$(./obj_dir/sim_execute_core || true)"
echo "$output"

if grep -qx "Simulation finished: PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- tb_exec_model.svh
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// One decoded instruction as driven into ID/EX
typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    instr_type_e           itype;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]       d1, d2, imm;
    logic                  alu_src, mw, mr, m2r, we, br;
    logic [ROB_IDX_W-1:0]  rob;
    logic [EXC_W-1:0]      exc;
    logic                  b1, b2;
    logic [XLEN-1:0]       v1, v2;
} instr_t;

// The same instruction once it sits in EX/MEM
typedef struct packed {
    logic                  valid, we, mw, mr, m2r, br, complete, taken;
    logic [XLEN-1:0]       alu_out, store_data, target;
    logic [REG_ADDR_W-1:0] rd;
    logic [2:0]            funct3;
    instr_type_e           itype;
    logic [ROB_IDX_W-1:0]  idx;
    logic [EXC_W-1:0]      exc;
} result_t;

// Older result first, then ROB bypass, then register file
function automatic logic [XLEN-1:0] pick_operand(input logic [REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0] reg_val, input logic byp, input logic [XLEN-1:0] byp_val,
        input result_t older);
    if (older.valid && older.we && (older.rd != '0) && (older.rd == rs)) begin
        return older.alu_out;
    end
    if (byp) begin
        return byp_val;
    end
    return reg_val;
endfunction

function automatic logic [XLEN-1:0] alu_ref(input instr_t i, input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b);
    logic [XLEN-1:0]        y;
    logic [XLEN-1:0]        src;
    logic signed [XLEN-1:0] sa;
    src = (i.opcode == OPCODE_ALU_IMM || i.alu_src) ? i.imm : b;
    sa  = a;
    if (i.opcode == OPCODE_LOAD || i.opcode == OPCODE_STORE) begin
        return a + i.imm;
    end
    if (i.opcode != OPCODE_ALU && i.opcode != OPCODE_ALU_IMM) begin
        return '0;
    end
    case (i.funct3)
        3'd0: y = (i.opcode == OPCODE_ALU && i.funct7 == FUNCT7_ALT) ? a - src : a + src;
        3'd1: y = a << src[4:0];
        3'd2: y = ($signed(a) < $signed(src)) ? 32'd1 : 32'd0;
        3'd3: y = (a < src) ? 32'd1 : 32'd0;
        3'd4: y = a ^ src;
        3'd5: begin
            if (i.funct7 == FUNCT7_ALT) begin
                y = sa >>> src[4:0];
            end else begin
                y = a >> src[4:0];
            end
        end
        3'd6: y = a | src;
        default: y = a & src;
    endcase
    return y;
endfunction

function automatic logic taken_ref(input instr_t i, input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b);
    if (i.opcode != OPCODE_BRANCH) begin
        return 1'b0;
    end
    case (i.funct3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        3'd7: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// What the EX stage makes of i while older sits in EX/MEM
function automatic result_t exec_ref(input instr_t i, input result_t older);
    result_t         r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = pick_operand(i.rs1, i.d1, i.b1, i.v1, older);
    b = pick_operand(i.rs2, i.d2, i.b2, i.v2, older);
    r = '0;
    r.valid      = i.valid;
    r.we         = i.valid && i.we;
    r.mw         = i.valid && i.mw;
    r.mr         = i.valid && i.mr;
    r.m2r        = i.m2r;
    r.br         = i.valid && i.br;
    r.complete   = i.valid && (i.itype == INSTR_TYPE_ALU) &&
                   (i.opcode == OPCODE_ALU || i.opcode == OPCODE_ALU_IMM);
    r.taken      = i.valid && taken_ref(i, a, b);
    r.alu_out    = alu_ref(i, a, b);
    r.store_data = b;
    r.target     = i.pc + i.imm;
    r.rd         = i.rd;
    r.funct3     = i.funct3;
    r.itype      = i.itype;
    r.idx        = i.rob;
    r.exc        = i.exc;
    return r;
endfunction

`endif

//--- tb_execute_core.sv
`timescale 1ns/10ps

module tb_execute_core;
    import riscv_isa_pkg::*;
    import exec_cfg_pkg::*;

    `include "tb_exec_model.svh"

    localparam int          NUM_INSTR  = 2000;
    localparam int          CLK_PERIOD = 4;
    localparam logic [31:0] SEED       = 32'h05b0_af1c;

    logic                  clk;
    logic                  rst_n;
    logic                  stall;
    instr_t                cur;
    logic                  flush;
    logic [XLEN-1:0]       branch_target;
    logic [REG_ADDR_W-1:0] rs1_rob, rs2_rob, mem_rd;
    logic                  mem_valid, mem_complete;
    logic [XLEN-1:0]       mem_alu_out, mem_store_data;
    logic [2:0]            mem_funct3;
    instr_type_e           mem_instr_type;
    logic                  mem_mem_write, mem_mem_read, mem_mem_to_reg;
    logic                  mem_write_enable, mem_branch_inst;
    logic [EXC_W-1:0]      mem_exception;
    logic [ROB_IDX_W-1:0]  mem_complete_idx;

    // Model state, one slot per pipeline register
    instr_t                ex_m;
    result_t               mem_m;
    logic [XLEN-1:0]       regs [32];
    logic [ROB_IDX_W-1:0]  rob_next;
    logic [ROB_IDX_W-1:0]  rob_order [$];
    int                    sent, retired, err_value, err_other;

    execute_core u_execute_core (
        .id_valid(cur.valid), .id_pc(cur.pc), .id_opcode(cur.opcode),
        .id_funct3(cur.funct3), .id_funct7(cur.funct7), .id_instr_type(cur.itype),
        .id_rs1(cur.rs1), .id_rs2(cur.rs2), .id_rd(cur.rd),
        .id_data_rs1(cur.d1), .id_data_rs2(cur.d2), .id_immediate(cur.imm),
        .id_alu_src(cur.alu_src), .id_mem_write(cur.mw), .id_mem_read(cur.mr),
        .id_mem_to_reg(cur.m2r), .id_write_enable(cur.we), .id_branch_inst(cur.br),
        .id_rob_idx(cur.rob), .id_exception(cur.exc),
        .id_rs1_rob_bypass(cur.b1), .id_rs1_rob_value(cur.v1),
        .id_rs2_rob_bypass(cur.b2), .id_rs2_rob_value(cur.v2),
        .*
    );

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("Fail @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic make_instr();
        logic [31:0] r;
        int          kind;
        r    = $urandom;
        kind = $urandom_range(0, 4);
        cur  = '0;
        cur.valid  = ($urandom_range(0, 7) != 0);
        cur.pc     = $urandom & 32'hffff_fffc;
        cur.funct3 = 3'($urandom_range(0, 7));
        cur.funct7 = r[31] ? FUNCT7_ALT : 7'd0;
        // Few registers, so back-to-back hazards are common
        cur.rs1    = 5'($urandom_range(0, 7));
        cur.rs2    = 5'($urandom_range(0, 7));
        cur.rd     = 5'($urandom_range(0, 7));
        // Stale when the instruction now in EX writes the same register
        cur.d1     = regs[cur.rs1];
        cur.d2     = regs[cur.rs2];
        cur.imm    = {{20{r[11]}}, r[11:0]};
        cur.b1     = (r[15:14] == 2'b00);
        cur.b2     = (r[17:16] == 2'b00);
        cur.v1     = $urandom;
        cur.v2     = $urandom;
        cur.rob    = rob_next;
        cur.exc    = r[20:18];
        case (kind)
            0: begin
                cur.opcode = OPCODE_ALU;
                cur.itype  = INSTR_TYPE_ALU;
                cur.we     = 1'b1;
            end
            1: begin
                cur.opcode  = OPCODE_ALU_IMM;
                cur.itype   = INSTR_TYPE_ALU;
                cur.alu_src = 1'b1;
                cur.we      = 1'b1;
            end
            2: begin
                cur.opcode  = OPCODE_LOAD;
                cur.itype   = INSTR_TYPE_LOAD;
                cur.alu_src = 1'b1;
                cur.mr      = 1'b1;
                cur.m2r     = 1'b1;
                cur.we      = 1'b1;
            end
            3: begin
                cur.opcode  = OPCODE_STORE;
                cur.itype   = INSTR_TYPE_STORE;
                cur.alu_src = 1'b1;
                cur.mw      = 1'b1;
            end
            default: begin
                cur.opcode = OPCODE_BRANCH;
                cur.itype  = INSTR_TYPE_BRANCH;
                cur.br     = 1'b1;
            end
        endcase
        if (cur.valid) begin
            rob_next = rob_next + 4'd1;
        end
    endtask

    // Model step for a rising edge with stall low
    task automatic advance_model();
        result_t nxt;
        nxt   = exec_ref(ex_m, mem_m);
        mem_m = nxt;
        // A taken branch squashes whatever ID offered at the same edge
        if (cur.valid && !nxt.taken) begin
            ex_m = cur;
            rob_order.push_back(cur.rob);
        end else begin
            ex_m = '0;
        end
        // Each instruction the DUT presents takes the oldest accepted index
        if (mem_valid) begin
            retired++;
            if (rob_order.size() == 0) begin
                err_other++;
                $display("An instruction reached the outputs that was never accepted");
            end else begin
                compare("ROB order", 32'(mem_complete_idx), 32'(rob_order.pop_front()));
            end
        end
        if (mem_m.valid && mem_m.we && (mem_m.rd != '0)) begin
            regs[mem_m.rd] = mem_m.alu_out;
        end
    endtask

    task automatic check_outputs();
        result_t in_ex;
        in_ex = exec_ref(ex_m, mem_m);
        compare("mem_valid", 32'(mem_valid), 32'(mem_m.valid));
        compare("mem_write_enable", 32'(mem_write_enable), 32'(mem_m.we));
        compare("mem_mem_write", 32'(mem_mem_write), 32'(mem_m.mw));
        compare("mem_mem_read", 32'(mem_mem_read), 32'(mem_m.mr));
        compare("mem_branch_inst", 32'(mem_branch_inst), 32'(mem_m.br));
        compare("mem_complete", 32'(mem_complete), 32'(mem_m.complete));
        compare("flush", 32'(flush), 32'(in_ex.taken));
        if (in_ex.taken) begin
            compare("branch_target", branch_target, in_ex.target);
        end
        if (ex_m.valid) begin
            compare("rs1_rob", 32'(rs1_rob), 32'(ex_m.rs1));
            compare("rs2_rob", 32'(rs2_rob), 32'(ex_m.rs2));
        end
        if (mem_m.valid) begin
            compare("mem_alu_out", mem_alu_out, mem_m.alu_out);
            compare("mem_store_data", mem_store_data, mem_m.store_data);
            compare("mem_rd", 32'(mem_rd), 32'(mem_m.rd));
            compare("mem_funct3", 32'(mem_funct3), 32'(mem_m.funct3));
            compare("mem_instr_type", 32'(mem_instr_type), 32'(mem_m.itype));
            compare("mem_mem_to_reg", 32'(mem_mem_to_reg), 32'(mem_m.m2r));
            compare("mem_complete_idx", 32'(mem_complete_idx), 32'(mem_m.idx));
            compare("mem_exception", 32'(mem_exception), 32'(mem_m.exc));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_INSTR * 3 * CLK_PERIOD + 1000);
        $display("Watchdog expired at %0t before the pipeline drained", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst_n     = 1'b0;
        stall     = 1'b0;
        cur       = '0;
        ex_m      = '0;
        mem_m     = '0;
        rob_next  = '0;
        sent      = 0;
        retired   = 0;
        err_value = 0;
        err_other = 0;
        for (int r = 0; r < 32; r++) begin
            regs[r] = (r == 0) ? '0 : $urandom;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_outputs();
        rst_n = 1'b1;
        while (sent < NUM_INSTR || ex_m.valid || mem_m.valid) begin
            @(negedge clk);
            // stall still holds what the last rising edge saw
            if (!stall) begin
                advance_model();
            end
            check_outputs();
            if (!stall) begin
                if (sent < NUM_INSTR) begin
                    make_instr();
                    sent++;
                end else begin
                    cur = '0;
                end
            end
            stall = ($urandom_range(0, 3) == 0);
        end
        if (rob_order.size() != 0) begin
            err_other++;
            $display("%0d accepted instructions never reached the outputs", rob_order.size());
        end
        $display("Run done: %0d retired, %0d value errors, %0d other errors",
                 retired, err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- execute_core.sv
`timescale 1ns/10ps

module execute_core (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   stall,
    input  logic                                   id_valid,
    input  logic [exec_cfg_pkg::XLEN-1:0]          id_pc,
    input  riscv_isa_pkg::opcode_e                 id_opcode,
    input  logic [2:0]                             id_funct3,
    input  logic [6:0]                             id_funct7,
    input  riscv_isa_pkg::instr_type_e             id_instr_type,
    input  logic [exec_cfg_pkg::REG_ADDR_W-1:0]    id_rs1, id_rs2, id_rd,
    input  logic [exec_cfg_pkg::XLEN-1:0]          id_data_rs1, id_data_rs2, id_immediate,
    input  logic                                   id_alu_src,
    input  logic                                   id_mem_write, id_mem_read, id_mem_to_reg,
    input  logic                                   id_write_enable, id_branch_inst,
    input  logic [exec_cfg_pkg::ROB_IDX_W-1:0]     id_rob_idx,
    input  logic [exec_cfg_pkg::EXC_W-1:0]         id_exception,
    input  logic                                   id_rs1_rob_bypass, id_rs2_rob_bypass,
    input  logic [exec_cfg_pkg::XLEN-1:0]          id_rs1_rob_value, id_rs2_rob_value,
    output logic                                   flush,
    output logic [exec_cfg_pkg::XLEN-1:0]          branch_target,
    output logic [exec_cfg_pkg::REG_ADDR_W-1:0]    rs1_rob, rs2_rob,
    output logic                                   mem_valid,
    output logic [exec_cfg_pkg::XLEN-1:0]          mem_alu_out, mem_store_data,
    output logic [exec_cfg_pkg::REG_ADDR_W-1:0]    mem_rd,
    output logic [2:0]                             mem_funct3,
    output riscv_isa_pkg::instr_type_e             mem_instr_type,
    output logic                                   mem_mem_write, mem_mem_read, mem_mem_to_reg,
    output logic                                   mem_write_enable, mem_branch_inst,
    output logic [exec_cfg_pkg::EXC_W-1:0]         mem_exception,
    output logic                                   mem_complete,
    output logic [exec_cfg_pkg::ROB_IDX_W-1:0]     mem_complete_idx
);
    import riscv_isa_pkg::*;
    import exec_cfg_pkg::*;

    // ID/EX outputs
    logic                  ex_valid;
    logic [XLEN-1:0]       ex_pc;
    opcode_e               ex_opcode;
    logic [2:0]            ex_funct3;
    logic [6:0]            ex_funct7;
    instr_type_e           ex_instr_type;
    logic [REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
    logic [XLEN-1:0]       ex_data_rs1, ex_data_rs2, ex_immediate;
    logic                  ex_alu_src;
    logic                  ex_mem_write, ex_mem_read, ex_mem_to_reg;
    logic                  ex_write_enable, ex_branch_inst;
    logic [ROB_IDX_W-1:0]  ex_rob_idx;
    logic [EXC_W-1:0]      ex_exception;
    logic                  ex_rs1_rob_bypass, ex_rs2_rob_bypass;
    logic [XLEN-1:0]       ex_rs1_rob_value, ex_rs2_rob_value;

    // Execute results into EX/MEM
    logic                  valid;
    logic [XLEN-1:0]       alu_out, store_data;
    logic [REG_ADDR_W-1:0] rd;
    logic [2:0]            funct3;
    instr_type_e           instr_type;
    logic                  mem_write, mem_read, mem_to_reg;
    logic                  write_enable, branch_inst;
    logic [EXC_W-1:0]      exception;
    logic                  complete;
    logic [ROB_IDX_W-1:0]  complete_idx;

    // Port names line up across the stages
    id_ex_reg     u_id_ex_reg     (.*);
    stage_execute u_stage_execute (.*);
    ex_mem_reg    u_ex_mem_reg    (.*);

endmodule

//--- ex_mem_reg.sv
`timescale 1ns/10ps

module ex_mem_reg (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   stall,
    input  logic                                   valid,
    input  logic [exec_cfg_pkg::XLEN-1:0]          alu_out, store_data,
    input  logic [exec_cfg_pkg::REG_ADDR_W-1:0]    rd,
    input  logic [2:0]                             funct3,
    input  riscv_isa_pkg::instr_type_e             instr_type,
    input  logic                                   mem_write, mem_read, mem_to_reg,
    input  logic                                   write_enable, branch_inst,
    input  logic [exec_cfg_pkg::EXC_W-1:0]         exception,
    input  logic                                   complete,
    input  logic [exec_cfg_pkg::ROB_IDX_W-1:0]     complete_idx,
    output logic                                   mem_valid,
    output logic [exec_cfg_pkg::XLEN-1:0]          mem_alu_out, mem_store_data,
    output logic [exec_cfg_pkg::REG_ADDR_W-1:0]    mem_rd,
    output logic [2:0]                             mem_funct3,
    output riscv_isa_pkg::instr_type_e             mem_instr_type,
    output logic                                   mem_mem_write, mem_mem_read, mem_mem_to_reg,
    output logic                                   mem_write_enable, mem_branch_inst,
    output logic [exec_cfg_pkg::EXC_W-1:0]         mem_exception,
    output logic                                   mem_complete,
    output logic [exec_cfg_pkg::ROB_IDX_W-1:0]     mem_complete_idx
);
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid        <= 1'b0;
            mem_complete     <= 1'b0;
            mem_mem_write    <= 1'b0;
            mem_mem_read     <= 1'b0;
            mem_write_enable <= 1'b0;
            mem_branch_inst  <= 1'b0;
        end else if (!stall) begin
            mem_valid        <= valid;
            mem_complete     <= complete;
            mem_mem_write    <= mem_write;
            mem_mem_read     <= mem_read;
            mem_write_enable <= write_enable;
            mem_branch_inst  <= branch_inst;
        end
    end

    // Branches pass too, the ROB needs their index
    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_alu_out      <= alu_out;
            mem_store_data   <= store_data;
            mem_rd           <= rd;
            mem_funct3       <= funct3;
            mem_instr_type   <= instr_type;
            mem_mem_to_reg   <= mem_to_reg;
            mem_exception    <= exception;
            mem_complete_idx <= complete_idx;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) mem_complete |-> mem_valid)
        else $error("ROB completion without a valid instruction");

endmodule

//--- id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   stall,
    input  logic                                   flush,
    input  logic                                   id_valid,
    input  logic [exec_cfg_pkg::XLEN-1:0]          id_pc,
    input  riscv_isa_pkg::opcode_e                 id_opcode,
    input  logic [2:0]                             id_funct3,
    input  logic [6:0]                             id_funct7,
    input  riscv_isa_pkg::instr_type_e             id_instr_type,
    input  logic [exec_cfg_pkg::REG_ADDR_W-1:0]    id_rs1, id_rs2, id_rd,
    input  logic [exec_cfg_pkg::XLEN-1:0]          id_data_rs1, id_data_rs2, id_immediate,
    input  logic                                   id_alu_src,
    input  logic                                   id_mem_write, id_mem_read, id_mem_to_reg,
    input  logic                                   id_write_enable, id_branch_inst,
    input  logic [exec_cfg_pkg::ROB_IDX_W-1:0]     id_rob_idx,
    input  logic [exec_cfg_pkg::EXC_W-1:0]         id_exception,
    input  logic                                   id_rs1_rob_bypass, id_rs2_rob_bypass,
    input  logic [exec_cfg_pkg::XLEN-1:0]          id_rs1_rob_value, id_rs2_rob_value,
    output logic                                   ex_valid,
    output logic [exec_cfg_pkg::XLEN-1:0]          ex_pc,
    output riscv_isa_pkg::opcode_e                 ex_opcode,
    output logic [2:0]                             ex_funct3,
    output logic [6:0]                             ex_funct7,
    output riscv_isa_pkg::instr_type_e             ex_instr_type,
    output logic [exec_cfg_pkg::REG_ADDR_W-1:0]    ex_rs1, ex_rs2, ex_rd,
    output logic [exec_cfg_pkg::XLEN-1:0]          ex_data_rs1, ex_data_rs2, ex_immediate,
    output logic                                   ex_alu_src,
    output logic                                   ex_mem_write, ex_mem_read, ex_mem_to_reg,
    output logic                                   ex_write_enable, ex_branch_inst,
    output logic [exec_cfg_pkg::ROB_IDX_W-1:0]     ex_rob_idx,
    output logic [exec_cfg_pkg::EXC_W-1:0]         ex_exception,
    output logic                                   ex_rs1_rob_bypass, ex_rs2_rob_bypass,
    output logic [exec_cfg_pkg::XLEN-1:0]          ex_rs1_rob_value, ex_rs2_rob_value
);
    logic take;

    // Taken branch in EX squashes the instruction behind it
    assign take = id_valid && !flush;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid        <= 1'b0;
            ex_mem_write    <= 1'b0;
            ex_mem_read     <= 1'b0;
            ex_write_enable <= 1'b0;
            ex_branch_inst  <= 1'b0;
        end else if (!stall) begin
            ex_valid        <= take;
            ex_mem_write    <= id_mem_write && take;
            ex_mem_read     <= id_mem_read && take;
            ex_write_enable <= id_write_enable && take;
            ex_branch_inst  <= id_branch_inst && take;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_pc             <= id_pc;
            ex_opcode         <= id_opcode;
            ex_funct3         <= id_funct3;
            ex_funct7         <= id_funct7;
            ex_instr_type     <= id_instr_type;
            ex_rs1            <= id_rs1;
            ex_rs2            <= id_rs2;
            ex_rd             <= id_rd;
            ex_data_rs1       <= id_data_rs1;
            ex_data_rs2       <= id_data_rs2;
            ex_immediate      <= id_immediate;
            ex_alu_src        <= id_alu_src;
            ex_mem_to_reg     <= id_mem_to_reg;
            ex_rob_idx        <= id_rob_idx;
            ex_exception      <= id_exception;
            ex_rs1_rob_bypass <= id_rs1_rob_bypass;
            ex_rs2_rob_bypass <= id_rs2_rob_bypass;
            ex_rs1_rob_value  <= id_rs1_rob_value;
            ex_rs2_rob_value  <= id_rs2_rob_value;
        end
    end

    // A bubble never writes anything
    assert property (@(posedge clk) disable iff (!rst_n)
        !ex_valid |-> !(ex_mem_write || ex_mem_read || ex_write_enable))
        else $error("bubble in ID/EX carries a write control");

endmodule

//--- stage_execute.sv
`timescale 1ns/10ps

module stage_execute (
    input  logic                                   ex_valid,
    input  logic [exec_cfg_pkg::XLEN-1:0]          ex_pc,
    input  riscv_isa_pkg::opcode_e                 ex_opcode,
    input  logic [2:0]                             ex_funct3,
    input  logic [6:0]                             ex_funct7,
    input  riscv_isa_pkg::instr_type_e             ex_instr_type,
    input  logic [exec_cfg_pkg::REG_ADDR_W-1:0]    ex_rs1, ex_rs2, ex_rd,
    input  logic [exec_cfg_pkg::XLEN-1:0]          ex_data_rs1, ex_data_rs2, ex_immediate,
    input  logic                                   ex_alu_src,
    input  logic                                   ex_mem_write, ex_mem_read, ex_mem_to_reg,
    input  logic                                   ex_write_enable, ex_branch_inst,
    input  logic [exec_cfg_pkg::ROB_IDX_W-1:0]     ex_rob_idx,
    input  logic [exec_cfg_pkg::EXC_W-1:0]         ex_exception,
    input  logic                                   ex_rs1_rob_bypass, ex_rs2_rob_bypass,
    input  logic [exec_cfg_pkg::XLEN-1:0]          ex_rs1_rob_value, ex_rs2_rob_value,
    input  logic [exec_cfg_pkg::REG_ADDR_W-1:0]    mem_rd,
    input  logic                                   mem_write_enable,
    input  logic                                   mem_valid,
    input  logic [exec_cfg_pkg::XLEN-1:0]          mem_alu_out,
    output logic [exec_cfg_pkg::XLEN-1:0]          alu_out, store_data, branch_target,
    output logic                                   flush,
    output logic [exec_cfg_pkg::REG_ADDR_W-1:0]    rd,
    output logic [2:0]                             funct3,
    output riscv_isa_pkg::instr_type_e             instr_type,
    output logic                                   mem_write, mem_read, mem_to_reg,
    output logic                                   write_enable, branch_inst,
    output logic [exec_cfg_pkg::EXC_W-1:0]         exception,
    output logic                                   complete,
    output logic [exec_cfg_pkg::ROB_IDX_W-1:0]     complete_idx,
    output logic [exec_cfg_pkg::REG_ADDR_W-1:0]    rs1_rob, rs2_rob,
    output logic                                   valid
);
    import riscv_isa_pkg::*;
    import exec_cfg_pkg::*;

    fwd_sel_e        forward_a;
    fwd_sel_e        forward_b;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_b;
    logic            branch_taken;

    forwarding_unit u_forwarding_unit (.*);

    // EX/MEM result beats ROB bypass beats register file
    assign operand_a = (forward_a == FWD_EXMEM) ? mem_alu_out      :
                       ex_rs1_rob_bypass        ? ex_rs1_rob_value :
                                                  ex_data_rs1;
    assign operand_b = (forward_b == FWD_EXMEM) ? mem_alu_out      :
                       ex_rs2_rob_bypass        ? ex_rs2_rob_value :
                                                  ex_data_rs2;

    // Store data must see the resolved rs2, not the raw register value
    assign store_data = operand_b;
    assign alu_b      = ex_alu_src ? ex_immediate : operand_b;

    alu u_alu (
        .opcode        (ex_opcode),
        .funct3        (ex_funct3),
        .funct7        (ex_funct7),
        .operand1      (operand_a),
        .operand2      (alu_b),
        .immediate     (ex_immediate),
        .pc            (ex_pc),
        .alu_out       (alu_out),
        .branch_target (branch_target),
        .branch_taken  (branch_taken)
    );

    assign flush = ex_valid && branch_taken;

    // ROB entry finishes here only for ALU work
    assign complete = ex_valid && (ex_instr_type == INSTR_TYPE_ALU) &&
                      ((ex_opcode == OPCODE_ALU) || (ex_opcode == OPCODE_ALU_IMM));
    assign complete_idx = ex_rob_idx;
    assign rs1_rob      = ex_rs1;
    assign rs2_rob      = ex_rs2;

    assign valid        = ex_valid;
    assign rd           = ex_rd;
    assign funct3       = ex_funct3;
    assign instr_type   = ex_instr_type;
    assign mem_write    = ex_mem_write;
    assign mem_read     = ex_mem_read;
    assign mem_to_reg   = ex_mem_to_reg;
    assign write_enable = ex_write_enable;
    assign branch_inst  = ex_branch_inst;
    assign exception    = ex_exception;

    // Decoder and ALU must agree on what a branch is
    always_comb begin
        assert (!flush || ex_branch_inst)
            else $error("flush raised for a non-branch instruction");
    end

endmodule

//--- alu.sv
`timescale 1ns/10ps

module alu (
    input  riscv_isa_pkg::opcode_e            opcode,
    input  logic [2:0]                        funct3,
    input  logic [6:0]                        funct7,
    input  logic [exec_cfg_pkg::XLEN-1:0]     operand1,
    input  logic [exec_cfg_pkg::XLEN-1:0]     operand2,
    input  logic [exec_cfg_pkg::XLEN-1:0]     immediate,
    input  logic [exec_cfg_pkg::XLEN-1:0]     pc,
    output logic [exec_cfg_pkg::XLEN-1:0]     alu_out,
    output logic [exec_cfg_pkg::XLEN-1:0]     branch_target,
    output logic                              branch_taken
);
    import riscv_isa_pkg::*;
    import exec_cfg_pkg::*;

    logic [XLEN-1:0] src_b;
    logic [4:0]      shamt;
    logic            use_sub;
    logic            cond;
    logic [XLEN-1:0] op_result;

    assign src_b   = (opcode == OPCODE_ALU_IMM) ? immediate : operand2;
    assign shamt   = src_b[4:0];
    // No subi in RV32I
    assign use_sub = (opcode == OPCODE_ALU) && (funct7 == FUNCT7_ALT);

    always_comb begin
        case (funct3_alu_e'(funct3))
            ALU_ADD_SUB: op_result = use_sub ? operand1 - src_b : operand1 + src_b;
            ALU_SLL:     op_result = operand1 << shamt;
            ALU_SLT:     op_result = {{(XLEN-1){1'b0}}, $signed(operand1) < $signed(src_b)};
            ALU_SLTU:    op_result = {{(XLEN-1){1'b0}}, operand1 < src_b};
            ALU_XOR:     op_result = operand1 ^ src_b;
            ALU_SRL_SRA: begin
                if (funct7 == FUNCT7_ALT) begin
                    op_result = XLEN'($signed(operand1) >>> shamt);
                end else begin
                    op_result = operand1 >> shamt;
                end
            end
            ALU_OR:      op_result = operand1 | src_b;
            default:     op_result = operand1 & src_b;
        endcase
    end

    always_comb begin
        case (funct3_br_e'(funct3))
            BR_BEQ:  cond = (operand1 == operand2);
            BR_BNE:  cond = (operand1 != operand2);
            BR_BLT:  cond = ($signed(operand1) < $signed(operand2));
            BR_BGE:  cond = ($signed(operand1) >= $signed(operand2));
            BR_BLTU: cond = (operand1 < operand2);
            BR_BGEU: cond = (operand1 >= operand2);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            OPCODE_ALU, OPCODE_ALU_IMM: alu_out = op_result;
            // Effective address
            OPCODE_LOAD, OPCODE_STORE:  alu_out = operand1 + immediate;
            default:                    alu_out = '0;
        endcase
    end

    assign branch_target = pc + immediate;
    assign branch_taken  = (opcode == OPCODE_BRANCH) && cond;

endmodule

//--- forwarding_unit.sv
`timescale 1ns/10ps

module forwarding_unit (
    input  logic [exec_cfg_pkg::REG_ADDR_W-1:0] ex_rs1,
    input  logic [exec_cfg_pkg::REG_ADDR_W-1:0] ex_rs2,
    input  logic [exec_cfg_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic                                mem_write_enable,
    input  logic                                mem_valid,
    output exec_cfg_pkg::fwd_sel_e              forward_a,
    output exec_cfg_pkg::fwd_sel_e              forward_b
);
    import exec_cfg_pkg::*;

    logic mem_produces;

    // Older instruction writes a real register, x0 never forwards
    assign mem_produces = mem_valid && mem_write_enable && (mem_rd != '0);

    assign forward_a = (mem_produces && (mem_rd == ex_rs1)) ? FWD_EXMEM : FWD_NONE;
    assign forward_b = (mem_produces && (mem_rd == ex_rs2)) ? FWD_EXMEM : FWD_NONE;

endmodule

//--- exec_cfg_pkg.sv
package exec_cfg_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ROB_IDX_W  = 4;
    localparam int EXC_W      = 3;

    // Operand source select, EX/MEM only
    typedef enum logic [1:0] {
        FWD_NONE  = 2'b00,
        FWD_EXMEM = 2'b10
    } fwd_sel_e;

endpackage

//--- riscv_isa_pkg.sv
package riscv_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPCODE_LOAD    = 7'b0000011,
        OPCODE_ALU_IMM = 7'b0010011,
        OPCODE_STORE   = 7'b0100011,
        OPCODE_ALU     = 7'b0110011,
        OPCODE_BRANCH  = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD_SUB = 3'b000,
        ALU_SLL     = 3'b001,
        ALU_SLT     = 3'b010,
        ALU_SLTU    = 3'b011,
        ALU_XOR     = 3'b100,
        ALU_SRL_SRA = 3'b101,
        ALU_OR      = 3'b110,
        ALU_AND     = 3'b111
    } funct3_alu_e;

    // Branch conditions, 3'b010 and 3'b011 are unused
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } funct3_br_e;

    typedef enum logic [2:0] {
        INSTR_TYPE_ALU    = 3'd0,
        INSTR_TYPE_LOAD   = 3'd1,
        INSTR_TYPE_STORE  = 3'd2,
        INSTR_TYPE_BRANCH = 3'd3
    } instr_type_e;

    // funct7 selecting sub and sra
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage
